// File: logic/riscv_hzrd_pkg.sv
package riscv_hzrd_pkg;

  // per-instruction fields the hazard logic looks at
  // an all-zero word is a bubble
  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic [6:0] opcode;
    logic       regw;
    logic [1:0] resultsrc;
    logic       iscsr;
    logic       mul_en;
    logic       div_en;
  } stage_info_t;

  // stall and flush levels, one per pipeline register
  typedef struct packed {
    logic stallpc;
    logic stallfd;
    logic flushfd;
    logic flushde;
    logic stallde;
    logic stallem;
    logic stallmw;
  } hzrd_ctrl_t;

  // operand mux select in execute
  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_WB   = 2'd1,
    FWD_MEM  = 2'd2,
    FWD_LUI  = 2'd3
  } fwd_sel_t;

  localparam logic [6:0] OPC_LUI = 7'b0110111;

  // resultsrc code for data coming back from memory
  localparam logic [1:0] RES_SRC_LOAD = 2'b10;

endpackage

// File: logic/riscv_hazardunit.sv
`timescale 1ns/1ps

module riscv_hazardunit (
  input  riscv_hzrd_pkg::stage_info_t i_dec_info,
  input  riscv_hzrd_pkg::stage_info_t i_info_e,
  input  riscv_hzrd_pkg::stage_info_t i_info_m,
  input  riscv_hzrd_pkg::stage_info_t i_info_w,
  input  logic                        i_pcsrc,
  input  logic                        i_dcache_stall,
  input  logic                        i_icache_stall,
  input  logic                        i_muldiv_valid,
  output riscv_hzrd_pkg::fwd_sel_t    o_fwda,
  output riscv_hzrd_pkg::fwd_sel_t    o_fwdb,
  output riscv_hzrd_pkg::hzrd_ctrl_t  o_ctrl,
  output logic                        o_passwb
);

  import riscv_hzrd_pkg::*;

  logic m_stall;
  logic glob_stall;
  logic rs1_hit_d;
  logic rs2_hit_d;
  logic use_src_e;
  logic use_hzrd_stall;
  logic use_hzrd_flush;

  // lui in memory first, then memory alu result, then writeback
  function automatic fwd_sel_t fwd_select(
    input logic [4:0]  rs,
    input stage_info_t mem,
    input stage_info_t wb
  );
    logic mem_hit;
    logic wb_hit;
    mem_hit = (rs == mem.rd) && mem.regw && (mem.rd != 5'd0);
    wb_hit  = (rs == wb.rd) && wb.regw && (wb.rd != 5'd0);
    if (mem_hit && (mem.opcode == OPC_LUI))
    begin
      fwd_select = FWD_LUI;
    end
    else if (mem_hit)
    begin
      fwd_select = FWD_MEM;
    end
    else if (wb_hit)
    begin
      fwd_select = FWD_WB;
    end
    else
    begin
      fwd_select = FWD_NONE;
    end
  endfunction

  assign o_fwda = fwd_select(i_info_e.rs1, i_info_m, i_info_w);
  assign o_fwdb = fwd_select(i_info_e.rs2, i_info_m, i_info_w);

  // muldiv still busy in execute
  assign m_stall    = (i_info_e.mul_en || i_info_e.div_en) && !i_muldiv_valid;
  assign glob_stall = i_dcache_stall || i_icache_stall || m_stall;

  assign rs1_hit_d = (i_dec_info.rs1 == i_info_e.rd);
  assign rs2_hit_d = (i_dec_info.rs2 == i_info_e.rd);

  // execute result not ready before memory for a load or a csr read feeding a non-csr
  assign use_src_e = (i_info_e.resultsrc == RES_SRC_LOAD) ||
                     (i_info_e.iscsr && !i_dec_info.iscsr);

  // csr decode ignores rs2 for the stall only
  assign use_hzrd_stall = (rs1_hit_d || (rs2_hit_d && !i_dec_info.iscsr)) && use_src_e;
  assign use_hzrd_flush = (rs1_hit_d || rs2_hit_d) && use_src_e;

  always_comb
  begin
    o_ctrl.stallpc = use_hzrd_stall || glob_stall;
    o_ctrl.stallfd = use_hzrd_stall || glob_stall;
    o_ctrl.stallde = glob_stall;
    o_ctrl.stallem = glob_stall;
    o_ctrl.stallmw = glob_stall;
    // a frozen pipe must not lose the instruction in decode or fetch
    o_ctrl.flushde = (use_hzrd_flush || i_pcsrc) && !glob_stall;
    o_ctrl.flushfd = i_pcsrc && !glob_stall;
  end

  // back-to-back csr ops on the same register
  assign o_passwb = i_info_m.iscsr && i_info_w.iscsr && (i_info_w.rd == i_info_m.rs1);

endmodule

// File: logic/riscv_stage_tracker.sv
`timescale 1ns/1ps

module riscv_stage_tracker (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  riscv_hzrd_pkg::stage_info_t i_dec_info,
  input  riscv_hzrd_pkg::hzrd_ctrl_t  i_ctrl,
  output riscv_hzrd_pkg::stage_info_t o_info_e,
  output riscv_hzrd_pkg::stage_info_t o_info_m,
  output riscv_hzrd_pkg::stage_info_t o_info_w
);

  // decode to execute
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      o_info_e <= '0;
    end
    else if (i_ctrl.stallde)
    begin
      o_info_e <= o_info_e;
    end
    else if (i_ctrl.flushde)
    begin
      // bubble for a use hazard or a taken branch
      o_info_e <= '0;
    end
    else
    begin
      o_info_e <= i_dec_info;
    end
  end

  // execute to memory
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      o_info_m <= '0;
    end
    else if (!i_ctrl.stallem)
    begin
      o_info_m <= o_info_e;
    end
  end

  // memory to writeback
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      o_info_w <= '0;
    end
    else if (!i_ctrl.stallmw)
    begin
      o_info_w <= o_info_m;
    end
  end

endmodule

// File: logic/riscv_muldiv_timer.sv
`timescale 1ns/1ps

module riscv_muldiv_timer #(
  parameter int unsigned MUL_LAT = 3,
  parameter int unsigned DIV_LAT = 8
) (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  riscv_hzrd_pkg::stage_info_t i_info_e,
  input  riscv_hzrd_pkg::hzrd_ctrl_t  i_ctrl,
  output logic                        o_muldiv_valid
);

  localparam logic [3:0] MUL_TGT = 4'(MUL_LAT);
  localparam logic [3:0] DIV_TGT = 4'(DIV_LAT);

  logic       muldiv_e;
  logic [3:0] target;
  logic [3:0] cnt;

  assign muldiv_e = i_info_e.mul_en || i_info_e.div_en;

  // divide wins if both enables are set
  assign target = i_info_e.div_en ? DIV_TGT : MUL_TGT;

  assign o_muldiv_valid = muldiv_e && (cnt == target);

  // restart on every execute advance, saturate once done
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n || !i_ctrl.stallem)
    begin
      cnt <= 4'd0;
    end
    else if (muldiv_e && !o_muldiv_valid)
    begin
      cnt <= cnt + 4'd1;
    end
  end

endmodule

// File: logic/riscv_pipe_ctrl.sv
`timescale 1ns/1ps

module riscv_pipe_ctrl #(
  parameter int unsigned MUL_LAT = 3,
  parameter int unsigned DIV_LAT = 8
) (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  riscv_hzrd_pkg::stage_info_t i_dec_info,
  input  logic                        i_pcsrc,
  input  logic                        i_dcache_stall,
  input  logic                        i_icache_stall,
  output riscv_hzrd_pkg::fwd_sel_t    o_fwda,
  output riscv_hzrd_pkg::fwd_sel_t    o_fwdb,
  output riscv_hzrd_pkg::hzrd_ctrl_t  o_ctrl,
  output logic                        o_passwb
);

  import riscv_hzrd_pkg::*;

  stage_info_t info_e;
  stage_info_t info_m;
  stage_info_t info_w;
  logic        muldiv_valid;

  riscv_hazardunit u_hazardunit (
    .i_dec_info     (i_dec_info),
    .i_info_e       (info_e),
    .i_info_m       (info_m),
    .i_info_w       (info_w),
    .i_pcsrc        (i_pcsrc),
    .i_dcache_stall (i_dcache_stall),
    .i_icache_stall (i_icache_stall),
    .i_muldiv_valid (muldiv_valid),
    .o_fwda         (o_fwda),
    .o_fwdb         (o_fwdb),
    .o_ctrl         (o_ctrl),
    .o_passwb       (o_passwb)
  );

  riscv_stage_tracker u_stage_tracker (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_dec_info (i_dec_info),
    .i_ctrl     (o_ctrl),
    .o_info_e   (info_e),
    .o_info_m   (info_m),
    .o_info_w   (info_w)
  );

  riscv_muldiv_timer #(
    .MUL_LAT (MUL_LAT),
    .DIV_LAT (DIV_LAT)
  ) u_muldiv_timer (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_info_e       (info_e),
    .i_ctrl         (o_ctrl),
    .o_muldiv_valid (muldiv_valid)
  );

endmodule

// File: tb/riscv_clk_gen.sv
`timescale 1ns/1ps

module riscv_clk_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial
  begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  // release away from the active edge
  initial
  begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

// File: tb/riscv_pipe_ctrl_checker.sv
`timescale 1ns/1ps

module riscv_pipe_ctrl_checker #(
  parameter int unsigned MUL_LAT = 3,
  parameter int unsigned DIV_LAT = 8
) (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  riscv_hzrd_pkg::stage_info_t i_dec_info,
  input  logic                        i_pcsrc,
  input  logic                        i_dcache_stall,
  input  logic                        i_icache_stall,
  input  riscv_hzrd_pkg::fwd_sel_t    i_fwda,
  input  riscv_hzrd_pkg::fwd_sel_t    i_fwdb,
  input  riscv_hzrd_pkg::hzrd_ctrl_t  i_ctrl,
  input  logic                        i_passwb,
  output int                          o_err_count
);

  import riscv_hzrd_pkg::*;

  stage_info_t ref_e;
  stage_info_t ref_m;
  stage_info_t ref_w;
  int unsigned ref_cnt;
  int unsigned lat;
  logic        busy;
  logic        freeze;
  logic        late_e;
  logic        hit1;
  logic        hit2;
  hzrd_ctrl_t  exp_ctrl;
  fwd_sel_t    exp_fwda;
  fwd_sel_t    exp_fwdb;
  logic        exp_passwb;

  // x0 never matches, memory beats writeback
  function automatic fwd_sel_t expect_fwd(
    input logic [4:0]  rs,
    input stage_info_t m,
    input stage_info_t w
  );
    if (m.regw && (m.rd != 5'd0) && (m.rd == rs))
      return (m.opcode == OPC_LUI) ? FWD_LUI : FWD_MEM;
    if (w.regw && (w.rd != 5'd0) && (w.rd == rs))
      return FWD_WB;
    return FWD_NONE;
  endfunction

  task automatic check_val(input string name, input int exp_v, input int act_v);
    if (exp_v != act_v)
    begin
      $display("ERR %0t %s expected %0d got %0d", $time, name, exp_v, act_v);
      o_err_count = o_err_count + 1;
    end
  endtask

  always_comb
  begin
    lat      = ref_e.div_en ? DIV_LAT : MUL_LAT;
    busy     = (ref_e.mul_en || ref_e.div_en) && (ref_cnt < lat);
    freeze   = i_dcache_stall || i_icache_stall || busy;
    late_e   = (ref_e.resultsrc == RES_SRC_LOAD) || (ref_e.iscsr && !i_dec_info.iscsr);
    hit1     = (i_dec_info.rs1 == ref_e.rd);
    hit2     = (i_dec_info.rs2 == ref_e.rd);
    exp_ctrl.stallpc = freeze || (late_e && (hit1 || (hit2 && !i_dec_info.iscsr)));
    exp_ctrl.stallfd = exp_ctrl.stallpc;
    exp_ctrl.stallde = freeze;
    exp_ctrl.stallem = freeze;
    exp_ctrl.stallmw = freeze;
    exp_ctrl.flushde = !freeze && (i_pcsrc || (late_e && (hit1 || hit2)));
    exp_ctrl.flushfd = !freeze && i_pcsrc;
    exp_fwda   = expect_fwd(ref_e.rs1, ref_m, ref_w);
    exp_fwdb   = expect_fwd(ref_e.rs2, ref_m, ref_w);
    exp_passwb = ref_m.iscsr && ref_w.iscsr && (ref_w.rd == ref_m.rs1);
  end

  always @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      ref_e       <= '0;
      ref_m       <= '0;
      ref_w       <= '0;
      ref_cnt     <= 0;
      o_err_count = 0;
    end
    else
    begin
      check_val("fwda", int'(exp_fwda), int'(i_fwda));
      check_val("fwdb", int'(exp_fwdb), int'(i_fwdb));
      check_val("ctrl", int'(exp_ctrl), int'(i_ctrl));
      check_val("passwb", int'(exp_passwb), int'(i_passwb));
      // whole pipe moves or whole pipe holds
      if (!freeze)
      begin
        if (exp_ctrl.flushde)
          ref_e <= '0;
        else
          ref_e <= i_dec_info;
        ref_m   <= ref_e;
        ref_w   <= ref_m;
        ref_cnt <= 0;
      end
      else if (busy)
      begin
        ref_cnt <= ref_cnt + 1;
      end
    end
  end

endmodule

// File: tb/riscv_pipe_ctrl_properties.sv
`timescale 1ns/1ps

module riscv_pipe_ctrl_properties (
  input logic                        i_clk,
  input logic                        i_rst_n,
  input riscv_hzrd_pkg::hzrd_ctrl_t  i_ctrl,
  input riscv_hzrd_pkg::fwd_sel_t    i_fwda,
  input riscv_hzrd_pkg::stage_info_t i_info_e,
  input riscv_hzrd_pkg::stage_info_t i_info_m,
  input riscv_hzrd_pkg::stage_info_t i_info_w
);

  import riscv_hzrd_pkg::*;

  // a frozen pipe drops nothing and moves nothing
  a_frozen_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ctrl.stallde |=> $stable(i_info_e) && $stable(i_info_m) && $stable(i_info_w))
    else $error("a pipeline stage changed while the pipeline was frozen");

  a_stalls_equal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ctrl.stallde == i_ctrl.stallem) && (i_ctrl.stallem == i_ctrl.stallmw))
    else $error("stallde, stallem and stallmw differ");

  a_no_fwd_x0: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_info_e.rs1 == 5'd0) |-> (i_fwda == FWD_NONE))
    else $error("x0 forwarded on source A");

endmodule

bind riscv_pipe_ctrl riscv_pipe_ctrl_properties u_properties (
  .i_clk    (i_clk),
  .i_rst_n  (i_rst_n),
  .i_ctrl   (o_ctrl),
  .i_fwda   (o_fwda),
  .i_info_e (info_e),
  .i_info_m (info_m),
  .i_info_w (info_w)
);

// File: tb/riscv_pipe_ctrl_tb.sv
`timescale 1ns/1ps

module riscv_pipe_ctrl_tb;

  import riscv_hzrd_pkg::*;

  localparam int unsigned MUL_LAT = 3;
  localparam int unsigned DIV_LAT = 8;
  localparam int NUM_PHASES     = 6;
  localparam int PHASE_CYCLES   = 400;
  localparam int TIMEOUT_CYCLES = NUM_PHASES * PHASE_CYCLES + 5 + 395;

  logic        clk;
  logic        rst_n;
  stage_info_t dec_info;
  logic        pcsrc;
  logic        dcache_stall;
  logic        icache_stall;
  fwd_sel_t    fwda;
  fwd_sel_t    fwdb;
  hzrd_ctrl_t  ctrl;
  logic        passwb;
  int          err_count;
  logic [15:0] lfsr;
  int          cycle_count = 0;
  int          start_err;
  int          phases_ok;
  string       phase_name [NUM_PHASES] = '{"load", "lui", "csr", "muldiv", "branch", "cache"};

  riscv_clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  riscv_pipe_ctrl #(
    .MUL_LAT (MUL_LAT),
    .DIV_LAT (DIV_LAT)
  ) riscv_pipe_ctrl_i (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_dec_info     (dec_info),
    .i_pcsrc        (pcsrc),
    .i_dcache_stall (dcache_stall),
    .i_icache_stall (icache_stall),
    .o_fwda         (fwda),
    .o_fwdb         (fwdb),
    .o_ctrl         (ctrl),
    .o_passwb       (passwb)
  );

  riscv_pipe_ctrl_checker #(
    .MUL_LAT (MUL_LAT),
    .DIV_LAT (DIV_LAT)
  ) u_checker (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_dec_info     (dec_info),
    .i_pcsrc        (pcsrc),
    .i_dcache_stall (dcache_stall),
    .i_icache_stall (icache_stall),
    .i_fwda         (fwda),
    .i_fwdb         (fwdb),
    .i_ctrl         (ctrl),
    .i_passwb       (passwb),
    .o_err_count    (err_count)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    lfsr_next = {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val[i] = lfsr[0];
      lfsr   = lfsr_next(lfsr);
    end
  endtask

  // odds out of 16, raised for the behavior the phase targets
  task automatic draw_chance(input int p, input int kind, output logic hit);
    logic [15:0] v;
    int          odds;
    odds = (p == kind) ? 8 : ((kind >= 3) ? 1 : 3);
    draw_bits(4, v);
    hit = (int'(v[3:0]) < odds);
  endtask

  task automatic drive_cycle(input int p);
    stage_info_t info;
    logic [15:0] v;
    logic        hit;
    draw_bits(10, v);
    info.rs1  = {2'b00, v[2:0]};
    info.rs2  = {2'b00, v[5:3]};
    info.rd   = {2'b00, v[8:6]};
    info.regw = v[9];
    draw_chance(p, 0, hit);
    info.resultsrc = hit ? RES_SRC_LOAD : 2'b00;
    draw_chance(p, 1, hit);
    info.opcode = hit ? OPC_LUI : 7'b0110011;
    draw_chance(p, 2, hit);
    info.iscsr = hit;
    draw_chance(p, 3, hit);
    draw_bits(1, v);
    info.mul_en = hit && !v[0];
    info.div_en = hit && v[0];
    dec_info = info;
    draw_chance(p, 4, hit);
    pcsrc = hit;
    draw_chance(p, 5, hit);
    dcache_stall = hit;
    draw_chance(p, 5, hit);
    icache_stall = hit;
  endtask

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial
  begin
    lfsr         = 16'd18955;
    dec_info     = '0;
    pcsrc        = 1'b0;
    dcache_stall = 1'b0;
    icache_stall = 1'b0;
    phases_ok    = 0;
    @(posedge rst_n);
    for (int p = 0; p < NUM_PHASES; p++)
    begin
      start_err = err_count;
      repeat (PHASE_CYCLES)
      begin
        @(negedge clk);
        drive_cycle(p);
      end
      // last drive checked on the edge before this one
      @(negedge clk);
      $display("phase %0d %s: %0d errors", p, phase_name[p], err_count - start_err);
      if (err_count == start_err)
        phases_ok++;
    end
    $display("summary: %0d of %0d phases clean, %0d errors, %0d cycles",
             phases_ok, NUM_PHASES, err_count, cycle_count);
    if (err_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: files.f
logic/riscv_hzrd_pkg.sv
logic/riscv_hazardunit.sv
logic/riscv_stage_tracker.sv
logic/riscv_muldiv_timer.sv
logic/riscv_pipe_ctrl.sv
tb/riscv_clk_gen.sv
tb/riscv_pipe_ctrl_checker.sv
tb/riscv_pipe_ctrl_properties.sv
tb/riscv_pipe_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# build and run the pipeline control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
  --top-module riscv_pipe_ctrl_tb -Mdir obj_dir -o sim_pipe_ctrl
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/sim_pipe_ctrl)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^ALL TESTS PASSED$"; then
  exit 0
fi
exit 1
